// ==== files.f ====
+incdir+hw
hw/exec_pkg.sv
hw/wb_scoreboard.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/exec_issue.sv
hw/exec_top.sv
tests/tb_clock.sv
tests/tb_exec_top.sv

// ==== Makefile ====
# Verilator build and run of the execute-stage testbench

BIN  = obj_dir/Vtb_exec_top
SRCS = $(shell grep -v '^+' files.f)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS) hw/exec_cfg.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_exec_top \
		-f files.f -o Vtb_exec_top

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== tests/tb_exec_top.sv ====
// Testbench of the execute stage; predicts ready levels and writebacks and checks both each cycle
`timescale 1ns/1ns
`include "exec_cfg.svh"

module tb_exec_top;

    import exec_pkg::*;

    localparam int RING       = 64;                                  // Model horizon in cycles
    localparam int RAND_N     = 400;
    localparam int SEND_LIMIT = 2 * `EXEC_LAT_DIV64 + 8;
    localparam int MAX_CYCLES = RAND_N * (`EXEC_LAT_DIV64 + 4) + 3000;

    logic                  clk_i, rstn_i;
    logic                  instr_valid_i, kill_i, instr_ready_o;
    exec_op_e              instr_op_i;
    logic [`EXEC_RD_W-1:0] instr_rd_i, wb_rd_o;
    logic [`EXEC_XLEN-1:0] src1_i, src2_i, wb_data_o;
    logic                  wb_valid_o;

    int   cyc = 0;                     // Rising edges seen
    int   errors = 0;
    int   checks = 0;
    int   seed = 99;
    int   busy_last = -1;              // Last cycle the divider is busy
    logic last_pred;
    logic                  exp_valid [RING];   // Expected writeback per cycle
    logic [`EXEC_RD_W-1:0] exp_rd    [RING];
    logic [`EXEC_XLEN-1:0] exp_data  [RING];
    logic                  resv      [RING];   // Scoreboard reservations per cycle

    tb_clock u_clk (.clk_o(clk_i), .rstn_o(rstn_i));

    exec_top DUT (
        .clk_i(clk_i), .rstn_i(rstn_i), .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
        .instr_rd_i(instr_rd_i), .src1_i(src1_i), .src2_i(src2_i), .kill_i(kill_i),
        .instr_ready_o(instr_ready_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o)
    );

    task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, expv);
        end
    endtask

    // Result of an operation by the ISA rules
    function automatic logic [63:0] ref_result(exec_op_e op, logic [63:0] a, logic [63:0] b);
        logic [63:0]        p;
        logic signed [31:0] a32, b32, q32;
        logic signed [63:0] sa, sb, q64;
        p = a * b;
        a32 = a[31:0];
        b32 = b[31:0];
        sa = a;
        sb = b;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_MULW: return {{32{p[31]}}, p[31:0]};
            OP_MUL:  return p;
            OP_DIVW: begin
                if (b32 == 0) return '1;                        // Divide by zero gives all ones
                q32 = (a32 == 32'sh80000000 && b32 == -1) ? a32 : a32 / b32;
                return {{32{q32[31]}}, q32};
            end
            OP_DIV: begin
                if (sb == 0) return '1;
                q64 = (sa == 64'sh8000000000000000 && sb == -1) ? sa : sa / sb;
                return q64;
            end
            default: return '0;
        endcase
    endfunction

    // Edges from acceptance to writeback, also the reserved distance
    function automatic int sb_latency(exec_op_e op);
        case (op)
            OP_MULW: return `EXEC_LAT_MUL32;
            OP_MUL:  return `EXEC_LAT_MUL64;
            OP_DIVW: return `EXEC_LAT_DIV32;
            OP_DIV:  return `EXEC_LAT_DIV64;
            default: return `EXEC_LAT_ALU;
        endcase
    endfunction

    function automatic logic predict_ready(exec_op_e op, logic kil);
        logic free;
        free = !resv[(cyc + sb_latency(op)) % RING];
        if (kil) return 1'b0;
        if (op == OP_DIVW || op == OP_DIV) return free && (cyc > busy_last);
        return free;
    endfunction

    // One cycle of stimulus plus ready check and model update
    task automatic issue_cycle(input logic vld, input exec_op_e op, input logic [4:0] rd,
                               input logic [63:0] a, input logic [63:0] b, input logic kil,
                               output logic acc);
        int wb_at;
        @(negedge clk_i);
        resv[cyc % RING] = 1'b0;                            // Cycle is now, not future
        last_pred = predict_ready(op, kil);
        wb_at = (cyc + sb_latency(op)) % RING;
        instr_valid_i = vld;
        instr_op_i = op;
        instr_rd_i = rd;
        src1_i = a;
        src2_i = b;
        kill_i = kil;
        #1;
        check_value("instr_ready_o", 64'(instr_ready_o), 64'(last_pred));
        acc = instr_valid_i && instr_ready_o;
        if (kil) begin
            for (int i = 0; i < RING; i++) begin
                resv[i] = 1'b0;
                if (i != cyc % RING) exp_valid[i] = 1'b0;   // Current writeback still shows
            end
            busy_last = cyc;
        end
        if (acc) begin
            if (sb_latency(op) > 1) resv[(cyc + sb_latency(op)) % RING] = 1'b1;
            if (op == OP_DIVW || op == OP_DIV) busy_last = cyc + sb_latency(op) - 1;
            exp_valid[wb_at] = 1'b1;
            exp_rd[wb_at] = rd;
            exp_data[wb_at] = ref_result(op, a, b);
        end
    endtask

    task automatic send(input exec_op_e op, input logic [4:0] rd, input logic [63:0] a,
                        input logic [63:0] b, output int acc_cyc);
        logic acc;
        int   tries;
        acc = 1'b0;
        tries = 0;
        acc_cyc = -1;
        while (!acc && tries < SEND_LIMIT) begin
            issue_cycle(1'b1, op, rd, a, b, 1'b0, acc);
            if (acc) acc_cyc = cyc;
            tries++;
        end
        if (!acc) begin
            errors++;
            $display("Error at %0t: %s was never accepted", $time, op.name());
        end
    endtask

    task automatic idle(input int n);
        logic acc;
        repeat (n) issue_cycle(1'b0, OP_ADD, 5'd0, 64'd0, 64'd0, 1'b0, acc);
    endtask

    task automatic finish_test(input string name, input int err_start);
        idle(`EXEC_LAT_DIV64 + 4);                          // Drain before the next test
        $display("Test %-9s %s (%0d errors)", name,
                 (errors == err_start) ? "ok" : "bad", errors - err_start);
    endtask

    function automatic logic [63:0] pick_operand();
        int r;
        r = {$random(seed)} % 8;
        case (r)
            0: return 64'd0;
            1: return '1;                                   // -1
            2: return 64'h8000000000000000;
            3: return 64'hffffffff80000000;                 // Most negative word
            default: return {$random(seed), $random(seed)};
        endcase
    endfunction

    // Writeback compare, once per cycle while outputs are settled
    always @(negedge clk_i) begin : compare
        int idx;
        idx = cyc % RING;
        if (rstn_i) begin
            check_value("wb_valid_o", 64'(wb_valid_o), 64'(exp_valid[idx]));
            if (exp_valid[idx] && wb_valid_o) begin
                check_value("wb_rd_o", 64'(wb_rd_o), 64'(exp_rd[idx]));
                check_value("wb_data_o", wb_data_o, exp_data[idx]);
            end
            exp_valid[idx] = 1'b0;
        end
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run passed %0d cycles without finishing", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin : main
        int   e0, c0, c1, r;
        logic acc;
        logic [63:0] da [6];
        logic [63:0] db [6];
        instr_valid_i = 1'b0;
        instr_op_i = OP_ADD;
        instr_rd_i = '0;
        src1_i = '0;
        src2_i = '0;
        kill_i = 1'b0;
        for (int i = 0; i < RING; i++) begin
            exp_valid[i] = 1'b0;
            resv[i] = 1'b0;
        end
        da = '{64'd100, -64'd100, 64'h8000000000000000, 64'd12345, 64'h80000000,
               64'hdeadbeef00000007};
        db = '{64'd7, 64'd7, '1, 64'd0, 64'hffffffff, 64'h12345678fffffffd};
        wait (rstn_i === 1'b1);

        e0 = errors;                                        // ALU ops, one cycle each
        for (int i = 0; i < 20; i++)
            send(exec_op_e'(4'(i % 5)), 5'(i), pick_operand(), pick_operand(), c0);
        finish_test("alu", e0);

        e0 = errors;                                        // MULs back to back, then a mix
        send(OP_MUL, 5'd1, pick_operand(), pick_operand(), c0);
        for (int i = 0; i < 7; i++) send(OP_MUL, 5'(i + 2), pick_operand(), pick_operand(), c1);
        check_value("mul issue spacing", 64'(c1 - c0), 64'd7);
        for (int i = 0; i < 16; i++)
            send(({$random(seed)} % 2) ? OP_MUL : OP_MULW, 5'(i), pick_operand(),
                 pick_operand(), c1);
        finish_test("mul", e0);

        e0 = errors;                                        // Division corner cases
        for (int i = 0; i < 6; i++) begin
            send(OP_DIV, 5'(i), da[i], db[i], c0);
            issue_cycle(1'b1, OP_DIVW, 5'(i + 8), da[i], db[i], 1'b0, acc);
            check_value("second division refused", 64'(acc), 64'd0);
            if (acc == 1'b0) send(OP_DIVW, 5'(i + 8), da[i], db[i], c0);
        end
        finish_test("div", e0);

        e0 = errors;                                        // ALU lands on a DIVW reservation
        send(OP_DIVW, 5'd3, 64'd1000, 64'd7, c0);
        idle(`EXEC_LAT_DIV32 - 2);
        issue_cycle(1'b1, OP_ADD, 5'd4, 64'd1, 64'd2, 1'b0, acc);
        check_value("model ready for clashing ALU", 64'(last_pred), 64'd0);
        if (acc == 1'b0) send(OP_ADD, 5'd4, 64'd1, 64'd2, c1);
        finish_test("conflict", e0);

        e0 = errors;                                        // Flush of long ops
        send(OP_DIV, 5'd5, 64'd99, 64'd3, c0);
        send(OP_MUL, 5'd6, 64'd5, 64'd6, c0);
        send(OP_MULW, 5'd7, 64'd7, 64'd8, c0);
        send(OP_MUL, 5'd8, 64'd9, 64'd10, c0);
        issue_cycle(1'b0, OP_ADD, 5'd0, 64'd0, 64'd0, 1'b1, acc);
        issue_cycle(1'b0, OP_ADD, 5'd0, 64'd0, 64'd0, 1'b0, acc);
        check_value("all classes ready after kill",
                    64'({DUT.rdy_alu, DUT.rdy_mul32, DUT.rdy_mul64, DUT.rdy_div32,
                         DUT.rdy_div64, !DUT.div_busy}), 64'h3f);
        finish_test("kill", e0);

        e0 = errors;                                        // Random mix
        for (int i = 0; i < RAND_N; i++) begin
            r = {$random(seed)} % 40;
            if (r == 0) issue_cycle(1'b0, OP_ADD, 5'd0, 64'd0, 64'd0, 1'b1, acc);
            else if (r < 6) idle(1);
            send(exec_op_e'(4'({$random(seed)} % 9)), 5'($random(seed)), pick_operand(),
                 pick_operand(), c0);
        end
        finish_test("random", e0);

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tests/tb_clock.sv ====
// Clock and reset source for the execute-stage testbench; 20 ns period, reset held 5 cycles
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;            // 20 ns period
    end

    initial begin
        rstn_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;                         // Release away from the active edge
    end

endmodule

// ==== hw/exec_top.sv ====
// Execute stage top; joins issue, scoreboard and units and drives the shared writeback port
`timescale 1ns/1ns
`include "exec_cfg.svh"

module exec_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  instr_valid_i,
    input  exec_pkg::exec_op_e    instr_op_i,
    input  logic [`EXEC_RD_W-1:0] instr_rd_i,
    input  logic [`EXEC_XLEN-1:0] src1_i,
    input  logic [`EXEC_XLEN-1:0] src2_i,
    input  logic                  kill_i,         // Flush of multi-cycle ops
    output logic                  instr_ready_o,
    output logic                  wb_valid_o,
    output logic [`EXEC_RD_W-1:0] wb_rd_o,
    output logic [`EXEC_XLEN-1:0] wb_data_o
);

    logic set_alu, set_mul32, set_mul64, set_div32, set_div64;
    logic rdy_alu, rdy_mul32, rdy_mul64, rdy_div32, rdy_div64;
    logic alu_start, mul_start, div_start;
    logic div_busy;

    logic                  alu_valid, mul_valid, div_valid;
    logic [`EXEC_RD_W-1:0] alu_rd, mul_rd, div_rd;
    logic [`EXEC_XLEN-1:0] alu_data, mul_data, div_data;

    exec_issue u_issue (
        .kill_i(kill_i), .instr_valid_i(instr_valid_i), .instr_op_i(instr_op_i),
        .ready_alu_i(rdy_alu), .ready_mul32_i(rdy_mul32), .ready_mul64_i(rdy_mul64),
        .ready_div32_i(rdy_div32), .ready_div64_i(rdy_div64), .div_busy_i(div_busy),
        .instr_ready_o(instr_ready_o),
        .set_alu_o(set_alu), .set_mul32_o(set_mul32), .set_mul64_o(set_mul64),
        .set_div32_o(set_div32), .set_div64_o(set_div64),
        .alu_start_o(alu_start), .mul_start_o(mul_start), .div_start_o(div_start)
    );

    wb_scoreboard u_sb (
        .clk_i(clk_i), .rstn_i(rstn_i), .kill_i(kill_i),
        .set_alu_i(set_alu), .set_mul32_i(set_mul32), .set_mul64_i(set_mul64),
        .set_div32_i(set_div32), .set_div64_i(set_div64),
        .ready_alu_o(rdy_alu), .ready_mul32_o(rdy_mul32), .ready_mul64_o(rdy_mul64),
        .ready_div32_o(rdy_div32), .ready_div64_o(rdy_div64)
    );

    alu_unit u_alu (
        .clk_i(clk_i), .rstn_i(rstn_i), .start_i(alu_start), .op_i(instr_op_i),
        .rd_i(instr_rd_i), .src1_i(src1_i), .src2_i(src2_i),
        .res_valid_o(alu_valid), .res_rd_o(alu_rd), .res_data_o(alu_data)
    );

    mul_unit u_mul (
        .clk_i(clk_i), .rstn_i(rstn_i), .kill_i(kill_i), .start_i(mul_start),
        .op_i(instr_op_i), .rd_i(instr_rd_i), .src1_i(src1_i), .src2_i(src2_i),
        .res_valid_o(mul_valid), .res_rd_o(mul_rd), .res_data_o(mul_data)
    );

    div_unit u_div (
        .clk_i(clk_i), .rstn_i(rstn_i), .kill_i(kill_i), .start_i(div_start),
        .op_i(instr_op_i), .rd_i(instr_rd_i), .src1_i(src1_i), .src2_i(src2_i),
        .busy_o(div_busy),
        .res_valid_o(div_valid), .res_rd_o(div_rd), .res_data_o(div_data)
    );

    // Shared writeback; the scoreboard keeps the unit valids exclusive
    assign wb_valid_o = alu_valid | mul_valid | div_valid;
    assign wb_rd_o    = alu_valid ? alu_rd   : (mul_valid ? mul_rd   : div_rd);
    assign wb_data_o  = alu_valid ? alu_data : (mul_valid ? mul_data : div_data);

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0({alu_valid, mul_valid, div_valid}))
        else $error("exec_top: writeback collision");

endmodule

// ==== hw/exec_issue.sv ====
// Issue logic of the execute stage; turns the operation into a class, a ready level and strobes
`timescale 1ns/1ns

module exec_issue (
    input  logic               kill_i,          // Blocks issue in the kill cycle
    input  logic               instr_valid_i,
    input  exec_pkg::exec_op_e instr_op_i,
    input  logic               ready_alu_i,     // Scoreboard levels
    input  logic               ready_mul32_i,
    input  logic               ready_mul64_i,
    input  logic               ready_div32_i,
    input  logic               ready_div64_i,
    input  logic               div_busy_i,      // Divider holds an op
    output logic               instr_ready_o,
    output logic               set_alu_o,       // Reservation strobes
    output logic               set_mul32_o,
    output logic               set_mul64_o,
    output logic               set_div32_o,
    output logic               set_div64_o,
    output logic               alu_start_o,     // Unit starts
    output logic               mul_start_o,
    output logic               div_start_o
);

    import exec_pkg::*;

    lat_class_e cls;          // Latency class of the presented op
    logic       class_ready;  // Slot free and unit able to take it
    logic       accept;       // Valid and ready this cycle

    always_comb begin
        case (instr_op_i)
            OP_MULW: cls = LAT_MUL32;
            OP_MUL:  cls = LAT_MUL64;
            OP_DIVW: cls = LAT_DIV32;
            OP_DIV:  cls = LAT_DIV64;
            default: cls = LAT_1;              // ALU ops
        endcase
    end

    always_comb begin
        case (cls)
            LAT_MUL32: class_ready = ready_mul32_i;
            LAT_MUL64: class_ready = ready_mul64_i;
            LAT_DIV32: class_ready = ready_div32_i & ~div_busy_i;
            LAT_DIV64: class_ready = ready_div64_i & ~div_busy_i;
            default:   class_ready = ready_alu_i;
        endcase
    end

    assign instr_ready_o = class_ready & ~kill_i;
    assign accept        = instr_valid_i & instr_ready_o;

    assign set_alu_o   = accept & (cls == LAT_1);
    assign set_mul32_o = accept & (cls == LAT_MUL32);
    assign set_mul64_o = accept & (cls == LAT_MUL64);
    assign set_div32_o = accept & (cls == LAT_DIV32);
    assign set_div64_o = accept & (cls == LAT_DIV64);

    assign alu_start_o = set_alu_o;
    assign mul_start_o = set_mul32_o | set_mul64_o;
    assign div_start_o = set_div32_o | set_div64_o;

endmodule

// ==== hw/div_unit.sv ====
// Iterative signed divider of the execute stage; one op at a time, busy blocks further issue
`timescale 1ns/1ns
`include "exec_cfg.svh"

module div_unit (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  kill_i,       // Abandons the op in progress
    input  logic                  start_i,      // Accepted DIVW or DIV
    input  exec_pkg::exec_op_e    op_i,
    input  logic [`EXEC_RD_W-1:0] rd_i,
    input  logic [`EXEC_XLEN-1:0] src1_i,
    input  logic [`EXEC_XLEN-1:0] src2_i,
    output logic                  busy_o,       // High until the result edge
    output logic                  res_valid_o,
    output logic [`EXEC_RD_W-1:0] res_rd_o,
    output logic [`EXEC_XLEN-1:0] res_data_o
);

    import exec_pkg::*;

    localparam int XLEN  = `EXEC_XLEN;
    localparam int CNT_W = $clog2(`EXEC_LAT_DIV64);

    logic              word_s;                    // DIVW on the inputs
    logic [XLEN-1:0]   a_s;                       // Dividend, sign-extended for DIVW
    logic [XLEN-1:0]   b_s;                       // Divisor, sign-extended for DIVW
    logic [XLEN-1:0]   a_abs;
    logic [XLEN-1:0]   b_abs;
    logic [CNT_W-1:0]  cnt_q;                     // Steps left before the final one
    logic              word_q;
    logic              neg_q;                     // Quotient gets negated
    logic [XLEN-1:0]   rem_q;                     // Partial remainder
    logic [XLEN-1:0]   quo_q;                     // Dividend bits out, quotient bits in
    logic [XLEN-1:0]   dvs_q;                     // Divisor magnitude
    logic [2*XLEN-1:0] step1;
    logic [2*XLEN-1:0] step2;
    logic [XLEN-1:0]   q_signed;

    // One restoring step; remainder stays below the divisor so its top bit is free
    function automatic logic [2*XLEN-1:0] div_step(input logic [XLEN-1:0] rem,
                                                   input logic [XLEN-1:0] quo,
                                                   input logic [XLEN-1:0] dvs);
        logic [XLEN-1:0] shifted;
        shifted = {rem[XLEN-2:0], quo[XLEN-1]};
        if (shifted >= dvs) begin
            return {shifted - dvs, quo[XLEN-2:0], 1'b1};
        end
        return {shifted, quo[XLEN-2:0], 1'b0};
    endfunction

    assign word_s = (op_i == OP_DIVW);
    assign a_s    = word_s ? {{(XLEN-32){src1_i[31]}}, src1_i[31:0]} : src1_i;
    assign b_s    = word_s ? {{(XLEN-32){src2_i[31]}}, src2_i[31:0]} : src2_i;
    assign a_abs  = a_s[XLEN-1] ? -a_s : a_s;
    assign b_abs  = b_s[XLEN-1] ? -b_s : b_s;

    // Two quotient bits per iteration
    assign step1 = div_step(rem_q, quo_q, dvs_q);
    assign step2 = div_step(step1[2*XLEN-1:XLEN], step1[XLEN-1:0], dvs_q);

    // Zero divisor leaves all ones; MIN / -1 wraps back to the dividend by itself
    // Last two quotient bits and the sign come together in the final cycle
    assign q_signed = neg_q ? -step2[XLEN-1:0] : step2[XLEN-1:0];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_o      <= 1'b0;
            res_valid_o <= 1'b0;
            cnt_q       <= '0;
        end else if (kill_i) begin
            busy_o      <= 1'b0;
            res_valid_o <= 1'b0;
            cnt_q       <= '0;
        end else begin
            res_valid_o <= 1'b0;                       // Result is a pulse
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= word_s ? CNT_W'(`EXEC_LAT_DIV32 - 2) : CNT_W'(`EXEC_LAT_DIV64 - 2);
            end else if (busy_o) begin
                if (cnt_q == '0) begin
                    busy_o      <= 1'b0;               // Last step and sign end the op
                    res_valid_o <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            rem_q    <= '0;
            quo_q    <= word_s ? {a_abs[31:0], 32'b0} : a_abs;  // Left-align the word dividend
            dvs_q    <= b_abs;
            word_q   <= word_s;
            neg_q    <= (a_s[XLEN-1] ^ b_s[XLEN-1]) & (b_s != '0);
            res_rd_o <= rd_i;
        end else if (busy_o && cnt_q != '0) begin
            rem_q <= step2[2*XLEN-1:XLEN];
            quo_q <= step2[XLEN-1:0];
        end else if (busy_o) begin
            res_data_o <= word_q ? {{(XLEN-32){q_signed[31]}}, q_signed[31:0]} : q_signed;
        end
    end

    // Issue must hold divisions back while one is running
    assert property (@(posedge clk_i) disable iff (!rstn_i) start_i |-> !busy_o)
        else $error("div_unit: start while busy");

endmodule

// ==== hw/mul_unit.sv ====
// Pipelined multiplier of the execute stage; MULW leaves after two edges and MUL after three
`timescale 1ns/1ns
`include "exec_cfg.svh"

module mul_unit (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  kill_i,       // Clears every stage valid
    input  logic                  start_i,      // Accepted MULW or MUL
    input  exec_pkg::exec_op_e    op_i,
    input  logic [`EXEC_RD_W-1:0] rd_i,
    input  logic [`EXEC_XLEN-1:0] src1_i,
    input  logic [`EXEC_XLEN-1:0] src2_i,
    output logic                  res_valid_o,
    output logic [`EXEC_RD_W-1:0] res_rd_o,
    output logic [`EXEC_XLEN-1:0] res_data_o
);

    import exec_pkg::*;

    localparam int XLEN = `EXEC_XLEN;

    logic                  v1_q, v2_q, v3_q;     // Stage valids
    logic                  w1_q, w2_q;           // Word op flag
    logic [`EXEC_RD_W-1:0] rd1_q, rd2_q, rd3_q;
    logic [XLEN-1:0]       a1_q, b1_q;           // Stage 1 operands
    logic [XLEN-1:0]       p2_q, p3_q;           // Low product

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else if (kill_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
            v3_q <= 1'b0;
        end else begin
            v1_q <= start_i;
            v2_q <= v1_q;
            v3_q <= v2_q & ~w2_q;                  // MULW already left at stage 2
        end
    end

    always_ff @(posedge clk_i) begin
        a1_q  <= src1_i;
        b1_q  <= src2_i;
        w1_q  <= (op_i == OP_MULW);
        rd1_q <= rd_i;
        p2_q  <= a1_q * b1_q;                      // Low 64 bits kept
        w2_q  <= w1_q;
        rd2_q <= rd1_q;
        p3_q  <= p2_q;
        rd3_q <= rd2_q;
    end

    assign res_valid_o = (v2_q & w2_q) | v3_q;
    assign res_rd_o    = v3_q ? rd3_q : rd2_q;
    assign res_data_o  = v3_q ? p3_q : {{(XLEN-32){p2_q[31]}}, p2_q[31:0]};

    // Reservations keep a MULW exit away from a MUL exit
    assert property (@(posedge clk_i) disable iff (!rstn_i) !(v2_q && w2_q && v3_q))
        else $error("mul_unit: MULW and MUL leave together");

endmodule

// ==== hw/alu_unit.sv ====
// Single-cycle ALU of the execute stage, started by the issue logic and read at writeback
`timescale 1ns/1ns
`include "exec_cfg.svh"

module alu_unit (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  start_i,      // Accepted ALU op
    input  exec_pkg::exec_op_e    op_i,
    input  logic [`EXEC_RD_W-1:0] rd_i,
    input  logic [`EXEC_XLEN-1:0] src1_i,
    input  logic [`EXEC_XLEN-1:0] src2_i,
    output logic                  res_valid_o,  // One-cycle pulse
    output logic [`EXEC_RD_W-1:0] res_rd_o,
    output logic [`EXEC_XLEN-1:0] res_data_o
);

    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] result;

    always_comb begin
        case (op_i)
            OP_ADD:  result = src1_i + src2_i;
            OP_SUB:  result = src1_i - src2_i;
            OP_AND:  result = src1_i & src2_i;
            OP_OR:   result = src1_i | src2_i;
            OP_XOR:  result = src1_i ^ src2_i;
            default: result = '0;                   // Not an ALU op
        endcase
    end

    // Valid is control and sees reset; kill does not reach a 1-cycle op
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= start_i;
        end
    end

    always_ff @(posedge clk_i) begin
        res_rd_o   <= rd_i;
        res_data_o <= result;
    end

endmodule

// ==== hw/wb_scoreboard.sv ====
// Writeback reservation shift register; tells the issue logic which latency classes may go now
`timescale 1ns/1ns
`include "exec_cfg.svh"

module wb_scoreboard (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic kill_i,         // Drops every reservation

    input  logic set_alu_i,      // Accepted ALU op
    input  logic set_mul32_i,    // Accepted MULW
    input  logic set_mul64_i,    // Accepted MUL
    input  logic set_div32_i,    // Accepted DIVW
    input  logic set_div64_i,    // Accepted DIV

    output logic ready_alu_o,    // Writeback free 1 edge ahead
    output logic ready_mul32_o,  // Writeback free 2 edges ahead
    output logic ready_mul64_o,  // Writeback free 3 edges ahead
    output logic ready_div32_o,  // Writeback free 17 edges ahead
    output logic ready_div64_o   // Writeback free 33 edges ahead
);

    localparam int DEPTH = `EXEC_SB_DEPTH;

    logic [DEPTH-1:0] slot_q;    // Bit k set means writeback taken k+1 edges from now
    logic [DEPTH-1:0] slot_d;

    always_comb begin
        slot_d = {1'b0, slot_q[DEPTH-1:1]};                        // Age by one edge
        // A new op claims slot L-1 now, which sits at L-2 after the edge
        if (set_mul32_i) slot_d[`EXEC_LAT_MUL32-2] = 1'b1;
        if (set_mul64_i) slot_d[`EXEC_LAT_MUL64-2] = 1'b1;
        if (set_div32_i) slot_d[`EXEC_LAT_DIV32-2] = 1'b1;
        if (set_div64_i) slot_d[`EXEC_LAT_DIV64-2] = 1'b1;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            slot_q <= '0;
        end else if (kill_i) begin
            slot_q <= '0;                                          // Flush pending writebacks
        end else begin
            slot_q <= slot_d;
        end
    end

    assign ready_alu_o   = ~slot_q[`EXEC_LAT_ALU-1];
    assign ready_mul32_o = ~slot_q[`EXEC_LAT_MUL32-1];
    assign ready_mul64_o = ~slot_q[`EXEC_LAT_MUL64-1];
    assign ready_div32_o = ~slot_q[`EXEC_LAT_DIV32-1];
    assign ready_div64_o = ~slot_q[`EXEC_LAT_DIV64-1];

    // Issue logic must never set a slot that another op already owns
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !((set_alu_i   && slot_q[`EXEC_LAT_ALU-1])   ||
          (set_mul32_i && slot_q[`EXEC_LAT_MUL32-1]) ||
          (set_mul64_i && slot_q[`EXEC_LAT_MUL64-1]) ||
          (set_div32_i && slot_q[`EXEC_LAT_DIV32-1]) ||
          (set_div64_i && slot_q[`EXEC_LAT_DIV64-1])))
        else $error("wb_scoreboard: reservation collision");

endmodule

// ==== hw/exec_pkg.sv ====
// Operation and latency-class types shared by the execute-stage RTL and its testbench
package exec_pkg;

    // Operations accepted by the stage
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,    // 64-bit add
        OP_SUB  = 4'd1,    // 64-bit subtract
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_MULW = 4'd5,    // Low 32 bits of product, sign-extended
        OP_MUL  = 4'd6,    // Low 64 bits of product
        OP_DIVW = 4'd7,    // Signed 32-bit quotient, sign-extended
        OP_DIV  = 4'd8     // Signed 64-bit quotient
    } exec_op_e;

    // Writeback latency classes seen by the scoreboard
    typedef enum logic [2:0] {
        LAT_1     = 3'd0,  // ALU
        LAT_MUL32 = 3'd1,
        LAT_MUL64 = 3'd2,
        LAT_DIV32 = 3'd3,
        LAT_DIV64 = 3'd4
    } lat_class_e;

endpackage

// ==== hw/exec_cfg.svh ====
// Width and latency constants of the execute stage, included by every RTL file that sizes a port
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

`define EXEC_XLEN       64                // Data width
`define EXEC_RD_W       5                 // Destination tag width

// Edges from acceptance to a valid result
`define EXEC_LAT_ALU    1
`define EXEC_LAT_MUL32  2
`define EXEC_LAT_MUL64  3
`define EXEC_LAT_DIV32  17
`define EXEC_LAT_DIV64  33

`define EXEC_SB_DEPTH   `EXEC_LAT_DIV64   // Longest latency sets the reservation span

`endif
